/* design/perf_mon_macros.svh */
`ifndef PERF_MON_MACROS_SVH
`define PERF_MON_MACROS_SVH

// Counter width, also the Wishbone data width
`define PERF_CNT_W 32

// Base of the register map, word aligned
`define PERF_BASE_ADDR 32'hF003_0000

// Enable registers, byte offsets from the base
`define PERF_INSTR_EN_OFS 32'h0000_0004
`define PERF_CACHE_EN_OFS 32'h0000_0008

// Counter blocks, byte offsets from the base
`define PERF_INSTR_BLK_OFS 32'h0000_0100
`define PERF_CACHE_BLK_OFS 32'h0000_0200

// Counters per block
`define PERF_INSTR_CNT_N 8
`define PERF_CACHE_CNT_N 8

// Counter k of a block sits at block offset + k * stride
`define PERF_REG_STRIDE 4

`endif

/* design/perf_mon_pkg.sv */
`include "perf_mon_macros.svh"

package perf_mon_pkg;

	// RV32 major opcodes seen by the instruction profiler
	typedef enum logic [6:0]
	{
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011,
		AMO    = 7'b0101111
	} rv_opcode_e;

	typedef struct packed
	{
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		rv_opcode_e opcode;
	} rv_r_type_t;

	typedef struct packed
	{
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		rv_opcode_e  opcode;
	} rv_i_type_t;

	// Same instruction word, register view and immediate view
	typedef union packed
	{
		rv_r_type_t r;
		rv_i_type_t i;
	} rv_instr_u;

	typedef enum logic [2:0]
	{
		CNT_LW, CNT_SW, CNT_ADD, CNT_SUB, CNT_BRANCH, CNT_JUMP, CNT_SYSTEM, CNT_ATOMIC
	} instr_cnt_e;

	typedef enum logic [2:0]
	{
		IC_REQ, IC_HIT, IC_MISS, IC_FILL, DC_REQ, DC_HIT, DC_MISS, DC_FILL
	} cache_cnt_e;

	typedef logic [`PERF_CNT_W-1:0] cnt_bank_t [`PERF_INSTR_CNT_N];

endpackage

/* design/instr_profiler.sv */
`timescale 1ns/1ns
`include "perf_mon_macros.svh"

module instr_profiler
	import perf_mon_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      en_i,
	input  rv_instr_u instr_i,
	input  logic      instr_valid_i,
	output cnt_bank_t cnt_o
);

	// Class of the current word and whether it is counted at all
	instr_cnt_e cls_idx;
	logic       cls_hit;

	always_comb
	begin
		cls_idx = CNT_LW;
		cls_hit = 1'b0;
		case (instr_i.r.opcode)
			LOAD:
			begin
				// Only word-sized loads
				cls_idx = CNT_LW;
				cls_hit = (instr_i.i.funct3 == 3'b010);
			end
			STORE:
			begin
				cls_idx = CNT_SW;
				cls_hit = (instr_i.r.funct3 == 3'b010);
			end
			OP:
			begin
				if (instr_i.r.funct3 == 3'b000 && instr_i.r.funct7 == 7'b0000000)
				begin
					cls_idx = CNT_ADD;
					cls_hit = 1'b1;
				end
				else if (instr_i.r.funct3 == 3'b000 && instr_i.r.funct7 == 7'b0100000)
				begin
					cls_idx = CNT_SUB;
					cls_hit = 1'b1;
				end
			end
			OP_IMM:
			begin
				// ADDI, the immediate field is don't care
				cls_idx = CNT_ADD;
				cls_hit = (instr_i.i.funct3 == 3'b000);
			end
			BRANCH:
			begin
				cls_idx = CNT_BRANCH;
				cls_hit = 1'b1;
			end
			JAL, JALR:
			begin
				cls_idx = CNT_JUMP;
				cls_hit = 1'b1;
			end
			SYSTEM:
			begin
				cls_idx = CNT_SYSTEM;
				cls_hit = 1'b1;
			end
			AMO:
			begin
				cls_idx = CNT_ATOMIC;
				cls_hit = 1'b1;
			end
			default:
			begin
				cls_hit = 1'b0;
			end
		endcase
	end

	// One counter at most per cycle, wraps at full width
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int k = 0; k < `PERF_INSTR_CNT_N; k++)
				cnt_o[k] <= '0;
		end
		else if (en_i && instr_valid_i && cls_hit)
		begin
			cnt_o[cls_idx] <= cnt_o[cls_idx] + 1'b1;
		end
	end

endmodule

/* design/cache_profiler.sv */
`timescale 1ns/1ns
`include "perf_mon_macros.svh"

module cache_profiler
	import perf_mon_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      en_i,
	input  logic      icache_req_i,
	input  logic      icache_miss_i,
	input  logic      icache_fill_i,
	input  logic      dcache_req_i,
	input  logic      dcache_hit_i,
	input  logic      dcache_fill_i,
	output cnt_bank_t cnt_o
);

	// One increment strobe per counter, several may fire together
	logic [`PERF_CACHE_CNT_N-1:0] inc;

	always_comb
	begin
		inc = '0;

		// Instruction cache reports misses
		inc[IC_REQ]  = icache_req_i;
		inc[IC_HIT]  = icache_req_i & ~icache_miss_i;
		inc[IC_MISS] = icache_req_i & icache_miss_i;
		inc[IC_FILL] = icache_fill_i;

		// Data cache reports hits instead
		inc[DC_REQ]  = dcache_req_i;
		inc[DC_HIT]  = dcache_req_i & dcache_hit_i;
		inc[DC_MISS] = dcache_req_i & ~dcache_hit_i;
		inc[DC_FILL] = dcache_fill_i;
	end

	// Fill counters accumulate cycles, so they measure fill latency
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int k = 0; k < `PERF_CACHE_CNT_N; k++)
				cnt_o[k] <= '0;
		end
		else if (en_i)
		begin
			for (int k = 0; k < `PERF_CACHE_CNT_N; k++)
			begin
				if (inc[k])
					cnt_o[k] <= cnt_o[k] + 1'b1;
			end
		end
	end

endmodule

/* design/perf_csr_bus.sv */
`timescale 1ns/1ns
`include "perf_mon_macros.svh"

module perf_csr_bus
	import perf_mon_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [31:0]            wb_adr_i,
	input  logic [`PERF_CNT_W-1:0] wb_dat_i,
	input  cnt_bank_t              instr_cnt_i,
	input  cnt_bank_t              cache_cnt_i,
	output logic [`PERF_CNT_W-1:0] wb_dat_o,
	output logic                   wb_ack_o,
	output logic                   instr_en_o,
	output logic                   cache_en_o
);

	localparam logic [31:0] INSTR_EN_ADDR  = `PERF_BASE_ADDR + `PERF_INSTR_EN_OFS;
	localparam logic [31:0] CACHE_EN_ADDR  = `PERF_BASE_ADDR + `PERF_CACHE_EN_OFS;
	localparam logic [31:0] INSTR_BLK_ADDR = `PERF_BASE_ADDR + `PERF_INSTR_BLK_OFS;
	localparam logic [31:0] CACHE_BLK_ADDR = `PERF_BASE_ADDR + `PERF_CACHE_BLK_OFS;

	localparam logic [31:0] INSTR_BLK_SPAN = `PERF_INSTR_CNT_N * `PERF_REG_STRIDE;
	localparam logic [31:0] CACHE_BLK_SPAN = `PERF_CACHE_CNT_N * `PERF_REG_STRIDE;
	localparam int INSTR_IDX_W = $clog2(`PERF_INSTR_CNT_N);
	localparam int CACHE_IDX_W = $clog2(`PERF_CACHE_CNT_N);

	logic [`PERF_CNT_W-1:0] instr_en_q;
	logic [`PERF_CNT_W-1:0] cache_en_q;

	logic                   wb_req;
	logic [31:0]            instr_rel;
	logic [31:0]            cache_rel;
	logic                   instr_sel;
	logic                   cache_sel;
	logic [INSTR_IDX_W-1:0] instr_idx;
	logic [CACHE_IDX_W-1:0] cache_idx;

	assign wb_req = wb_cyc_i & wb_stb_i;

	// Block decode, address relative to each block base, word aligned only
	assign instr_rel = wb_adr_i - INSTR_BLK_ADDR;
	assign cache_rel = wb_adr_i - CACHE_BLK_ADDR;
	assign instr_sel = (instr_rel < INSTR_BLK_SPAN) && (instr_rel[1:0] == 2'b00);
	assign cache_sel = (cache_rel < CACHE_BLK_SPAN) && (cache_rel[1:0] == 2'b00);
	assign instr_idx = instr_rel[INSTR_IDX_W+1:2];
	assign cache_idx = cache_rel[CACHE_IDX_W+1:2];

	// Profilers only look at bit 0
	assign instr_en_o = instr_en_q[0];
	assign cache_en_o = cache_en_q[0];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wb_ack_o   <= 1'b0;
			instr_en_q <= '0;
			cache_en_q <= '0;
		end
		else
		begin
			// Single cycle ack, dropped for a cycle if the request stays up
			wb_ack_o <= wb_req & ~wb_ack_o;

			if (wb_req && wb_we_i)
			begin
				if (wb_adr_i == INSTR_EN_ADDR)
					instr_en_q <= wb_dat_i;
				else if (wb_adr_i == CACHE_EN_ADDR)
					cache_en_q <= wb_dat_i;
			end
		end
	end

	// Read data follows the address, zero when idle or unmapped
	always_comb
	begin
		wb_dat_o = '0;
		if (wb_req && !wb_we_i)
		begin
			if (wb_adr_i == INSTR_EN_ADDR)
				wb_dat_o = instr_en_q;
			else if (wb_adr_i == CACHE_EN_ADDR)
				wb_dat_o = cache_en_q;
			else if (instr_sel)
				wb_dat_o = instr_cnt_i[instr_idx];
			else if (cache_sel)
				wb_dat_o = cache_cnt_i[cache_idx];
		end
	end

endmodule

/* design/perf_monitor_top.sv */
`timescale 1ns/1ns
`include "perf_mon_macros.svh"

module perf_monitor_top
	import perf_mon_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,

	// Core side
	input  rv_instr_u              instr_i,
	input  logic                   instr_valid_i,
	input  logic                   icache_req_i,
	input  logic                   icache_miss_i,
	input  logic                   icache_fill_i,
	input  logic                   dcache_req_i,
	input  logic                   dcache_hit_i,
	input  logic                   dcache_fill_i,

	// Wishbone slave
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [31:0]            wb_adr_i,
	input  logic [`PERF_CNT_W-1:0] wb_dat_i,
	output logic [`PERF_CNT_W-1:0] wb_dat_o,
	output logic                   wb_ack_o
);

	logic      instr_en;
	logic      cache_en;
	cnt_bank_t instr_cnt;
	cnt_bank_t cache_cnt;

	instr_profiler u_instr_profiler
	(
		.clk           (clk),
		.rst           (rst),
		.en_i          (instr_en),
		.instr_i       (instr_i),
		.instr_valid_i (instr_valid_i),
		.cnt_o         (instr_cnt)
	);

	cache_profiler u_cache_profiler
	(
		.clk           (clk),
		.rst           (rst),
		.en_i          (cache_en),
		.icache_req_i  (icache_req_i),
		.icache_miss_i (icache_miss_i),
		.icache_fill_i (icache_fill_i),
		.dcache_req_i  (dcache_req_i),
		.dcache_hit_i  (dcache_hit_i),
		.dcache_fill_i (dcache_fill_i),
		.cnt_o         (cache_cnt)
	);

	perf_csr_bus u_perf_csr_bus
	(
		.clk         (clk),
		.rst         (rst),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.instr_cnt_i (instr_cnt),
		.cache_cnt_i (cache_cnt),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.instr_en_o  (instr_en),
		.cache_en_o  (cache_en)
	);

endmodule

/* tb/perf_monitor_tb.sv */
`timescale 1ns/1ns
`include "perf_mon_macros.svh"

module perf_monitor_tb
	import perf_mon_pkg::*;
;

	localparam logic [31:0] INSTR_EN_ADDR  = `PERF_BASE_ADDR + `PERF_INSTR_EN_OFS;
	localparam logic [31:0] CACHE_EN_ADDR  = `PERF_BASE_ADDR + `PERF_CACHE_EN_OFS;
	localparam logic [31:0] INSTR_BLK_ADDR = `PERF_BASE_ADDR + `PERF_INSTR_BLK_OFS;
	localparam logic [31:0] CACHE_BLK_ADDR = `PERF_BASE_ADDR + `PERF_CACHE_BLK_OFS;

	// Cycle budget from the random traffic of all phases and every bus access
	localparam int STIM_CYCLES = 2000 + 2000 + 500 + 500;
	localparam int BUS_OPS     = 120;
	localparam int BUS_OP_LEN  = 5;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + BUS_OPS * BUS_OP_LEN + 10;

	logic        clk;
	logic        rst;
	logic [31:0] instr_word;
	logic        instr_valid;
	logic        icache_req;
	logic        icache_miss;
	logic        icache_fill;
	logic        dcache_req;
	logic        dcache_hit;
	logic        dcache_fill;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	logic [31:0] lcg_state = 32'd77801;
	logic [31:0] model_instr [8];
	logic [31:0] model_cache [8];
	logic [31:0] dut_instr [8];
	logic [31:0] dut_cache [8];
	logic        model_instr_en;
	logic        model_cache_en;
	int          cycle_cnt = 0;

	perf_monitor_top UUT
	(
		.clk           (clk),
		.rst           (rst),
		.instr_i       (instr_word),
		.instr_valid_i (instr_valid),
		.icache_req_i  (icache_req),
		.icache_miss_i (icache_miss),
		.icache_fill_i (icache_fill),
		.dcache_req_i  (dcache_req),
		.dcache_hit_i  (dcache_hit),
		.dcache_fill_i (dcache_fill),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_we_i       (wb_we),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_dat_o      (wb_dat_r),
		.wb_ack_o      (wb_ack)
	);

	always #5 clk = ~clk;

	// LCG step with the upper half folded into the weak low bits
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ {16'h0000, lcg_state[31:16]};
	endfunction

	// Counter index for an issued word or -1 when no class matches
	function automatic int classify_instr(input logic [31:0] w);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		opc = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		classify_instr = -1;
		if (opc == LOAD && f3 == 3'b010)
			classify_instr = CNT_LW;
		else if (opc == STORE && f3 == 3'b010)
			classify_instr = CNT_SW;
		else if (opc == OP && f3 == 3'b000 && f7 == 7'b0000000)
			classify_instr = CNT_ADD;
		else if (opc == OP_IMM && f3 == 3'b000)
			classify_instr = CNT_ADD;
		else if (opc == OP && f3 == 3'b000 && f7 == 7'b0100000)
			classify_instr = CNT_SUB;
		else if (opc == BRANCH)
			classify_instr = CNT_BRANCH;
		else if (opc == JAL || opc == JALR)
			classify_instr = CNT_JUMP;
		else if (opc == SYSTEM)
			classify_instr = CNT_SYSTEM;
		else if (opc == AMO)
			classify_instr = CNT_ATOMIC;
	endfunction

	// Mostly listed opcodes with some unlisted and fully random ones
	function automatic logic [31:0] make_instr(input logic [31:0] r, input logic [31:0] f);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		case (r[3:0])
			4'd0: opc = LOAD;
			4'd1: opc = STORE;
			4'd2, 4'd3: opc = OP;
			4'd4: opc = OP_IMM;
			4'd5: opc = BRANCH;
			4'd6: opc = JAL;
			4'd7: opc = JALR;
			4'd8: opc = SYSTEM;
			4'd9: opc = AMO;
			4'd10: opc = 7'b0110111;
			4'd11: opc = 7'b0010111;
			default: opc = r[10:4];
		endcase
		f3 = r[20] ? r[23:21] : (r[24] ? 3'b010 : 3'b000);
		case (r[12:11])
			2'd0: f7 = 7'h00;
			2'd1: f7 = 7'h20;
			default: f7 = r[19:13];
		endcase
		return {f7, f[4:0], f[9:5], f3, f[14:10], opc};
	endfunction

	task automatic stop_on_failure();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
				$time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic set_events_idle();
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr_word  = '0;
		icache_req  = 1'b0;
		icache_miss = 1'b0;
		icache_fill = 1'b0;
		dcache_req  = 1'b0;
		dcache_hit  = 1'b0;
		dcache_fill = 1'b0;
	endtask

	task automatic drive_random_cycle();
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] f;
		r = next_rand();
		w = next_rand();
		f = next_rand();
		@(posedge clk);
		#1;
		instr_valid = r[0] | r[1];
		instr_word  = make_instr(w, f);
		icache_req  = r[2];
		icache_miss = r[3] & r[4];
		icache_fill = r[5];
		dcache_req  = r[6];
		dcache_hit  = r[7] | r[8];
		dcache_fill = r[9] & r[10];
	endtask

	task automatic run_random(input int n);
		repeat (n)
			drive_random_cycle();
		set_events_idle();
	endtask

	// One Wishbone access with the ack due one cycle after the request
	task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		@(posedge clk);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		while (!wb_ack && waited < 2);
		if (!wb_ack)
		begin
			$display("Wishbone ack missing for 2 cycles, address 0x%08h", adr);
			stop_on_failure();
		end
		check_value("wb_ack_o latency", 32'd1, waited);
		rdat = wb_dat_r;
		// Request still held here and ack must not repeat
		@(posedge clk);
		#1;
		check_value("wb_ack_o", 32'd0, {31'd0, wb_ack});
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, unused);
		if (adr == INSTR_EN_ADDR)
			model_instr_en = dat[0];
		else if (adr == CACHE_EN_ADDR)
			model_cache_en = dat[0];
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
		wb_access(1'b0, adr, 32'd0, dat);
	endtask

	task automatic read_expect(input logic [31:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] d;
		wb_read(adr, d);
		check_value(name, exp, d);
	endtask

	task automatic check_banks();
		for (int k = 0; k < 8; k++)
		begin
			wb_read(INSTR_BLK_ADDR + 4 * k, dut_instr[k]);
			check_value($sformatf("instr_cnt[%0d]", k), model_instr[k], dut_instr[k]);
		end
		for (int k = 0; k < 8; k++)
		begin
			wb_read(CACHE_BLK_ADDR + 4 * k, dut_cache[k]);
			check_value($sformatf("cache_cnt[%0d]", k), model_cache[k], dut_cache[k]);
		end
		check_value("icache hit+miss", model_cache[IC_REQ],
			dut_cache[IC_HIT] + dut_cache[IC_MISS]);
		check_value("dcache hit+miss", model_cache[DC_REQ],
			dut_cache[DC_HIT] + dut_cache[DC_MISS]);
	endtask

	// Reference model sampling the same inputs as the DUT at each edge
	always @(posedge clk)
	begin : model_update
		int cls;
		if (!rst)
		begin
			cls = classify_instr(instr_word);
			if (model_instr_en && instr_valid && cls >= 0)
				model_instr[cls] = model_instr[cls] + 1;
			if (model_cache_en)
			begin
				if (icache_req)
				begin
					model_cache[IC_REQ] = model_cache[IC_REQ] + 1;
					if (icache_miss)
						model_cache[IC_MISS] = model_cache[IC_MISS] + 1;
					else
						model_cache[IC_HIT] = model_cache[IC_HIT] + 1;
				end
				if (dcache_req)
				begin
					model_cache[DC_REQ] = model_cache[DC_REQ] + 1;
					if (dcache_hit)
						model_cache[DC_HIT] = model_cache[DC_HIT] + 1;
					else
						model_cache[DC_MISS] = model_cache[DC_MISS] + 1;
				end
				if (icache_fill)
					model_cache[IC_FILL] = model_cache[IC_FILL] + 1;
				if (dcache_fill)
					model_cache[DC_FILL] = model_cache[DC_FILL] + 1;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_on_failure();
		end
	end

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		instr_word = '0;
		instr_valid = 1'b0;
		icache_req = 1'b0;
		icache_miss = 1'b0;
		icache_fill = 1'b0;
		dcache_req = 1'b0;
		dcache_hit = 1'b0;
		dcache_fill = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		model_instr_en = 1'b0;
		model_cache_en = 1'b0;
		for (int k = 0; k < 8; k++)
		begin
			model_instr[k] = '0;
			model_cache[k] = '0;
		end
		repeat (5)
			@(posedge clk);
		#1;
		rst = 1'b0;

		// Reset state and unmapped reads
		read_expect(INSTR_EN_ADDR, 32'd0, "instr_en");
		read_expect(CACHE_EN_ADDR, 32'd0, "cache_en");
		check_banks();
		read_expect(`PERF_BASE_ADDR, 32'd0, "unmapped base");
		read_expect(`PERF_BASE_ADDR + 32'h40, 32'd0, "unmapped 0x40");

		// Full width enable registers and counters that are not writable
		wb_write(INSTR_EN_ADDR, 32'h5A5A_A5A4);
		read_expect(INSTR_EN_ADDR, 32'h5A5A_A5A4, "instr_en");
		wb_write(CACHE_EN_ADDR, 32'hC3C3_3C3C);
		read_expect(CACHE_EN_ADDR, 32'hC3C3_3C3C, "cache_en");
		wb_write(INSTR_EN_ADDR, 32'd0);
		wb_write(CACHE_EN_ADDR, 32'd0);
		wb_write(INSTR_BLK_ADDR + 8, 32'hDEAD_BEEF);
		read_expect(INSTR_BLK_ADDR + 8, 32'd0, "instr_cnt[2]");
		wb_write(CACHE_BLK_ADDR + 4, 32'hDEAD_BEEF);
		read_expect(CACHE_BLK_ADDR + 4, 32'd0, "cache_cnt[1]");

		// Instruction profiler alone so cache traffic must not count
		wb_write(INSTR_EN_ADDR, 32'd1);
		run_random(2000);
		check_banks();

		// Both profilers running
		wb_write(CACHE_EN_ADDR, 32'd1);
		run_random(2000);
		check_banks();

		// Instruction block frozen while the cache block keeps counting
		wb_write(INSTR_EN_ADDR, 32'hFFFF_FFFE);
		read_expect(INSTR_EN_ADDR, 32'hFFFF_FFFE, "instr_en");
		run_random(500);
		check_banks();

		// And the other way round
		wb_write(INSTR_EN_ADDR, 32'd1);
		wb_write(CACHE_EN_ADDR, 32'hFFFF_FFFE);
		read_expect(CACHE_EN_ADDR, 32'hFFFF_FFFE, "cache_en");
		run_random(500);
		check_banks();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* perf_monitor_top.f */
+incdir+design
design/perf_mon_pkg.sv
design/instr_profiler.sv
design/cache_profiler.sv
design/perf_csr_bus.sv
design/perf_monitor_top.sv
tb/perf_monitor_tb.sv

/* Bender.yml */
package:
  name: perf_monitor

sources:
  - include_dirs:
      - design
    files:
      - design/perf_mon_pkg.sv
      - design/instr_profiler.sv
      - design/cache_profiler.sv
      - design/perf_csr_bus.sv
      - design/perf_monitor_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/perf_monitor_tb.sv
